// File: hdl/lc4_pkg.sv
// widths, register index type and encodings shared by the two-way lc4 core
// every design module pulls these in with a wildcard import
package lc4_pkg;

    parameter int XLEN  = 16;
    parameter int NREGS = 8;

    typedef logic [$clog2(NREGS)-1:0] reg_idx_t;

    // top four bits of the instruction word, only the kept groups are named
    typedef enum logic [3:0] {
        OP_NOP   = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_CONST = 4'b1001
    } opcode_e;

    // ALU_PASS_IMM serves CONST and every instruction that writes nothing
    typedef enum logic [2:0] {
        ALU_ADD      = 3'd0,
        ALU_MUL      = 3'd1,
        ALU_SUB      = 3'd2,
        ALU_AND      = 3'd3,
        ALU_NOT      = 3'd4,
        ALU_OR       = 3'd5,
        ALU_XOR      = 3'd6,
        ALU_PASS_IMM = 3'd7
    } alu_op_e;

endpackage

// File: hdl/lc4_decoder.sv
// instruction decoder for the reduced lc4 subset
// one copy per issue slot, purely combinational
module lc4_decoder
    import lc4_pkg::*;
(
    input  logic [XLEN-1:0] i_insn,
    output alu_op_e         o_alu_op,
    output reg_idx_t        o_rd,
    output reg_idx_t        o_rs,
    output reg_idx_t        o_rt,
    output logic            o_rs_use,
    output logic            o_rt_use,
    output logic            o_we,
    output logic [XLEN-1:0] o_imm
);

    opcode_e         opcode;
    logic [XLEN-1:0] imm5;
    logic [XLEN-1:0] imm9;

    assign opcode = opcode_e'(i_insn[15:12]);
    assign imm5   = {{(XLEN-5){i_insn[4]}}, i_insn[4:0]};
    assign imm9   = {{(XLEN-9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        // field positions are fixed across all kept formats
        o_rd     = i_insn[11:9];
        o_rs     = i_insn[8:6];
        o_rt     = i_insn[2:0];
        o_alu_op = ALU_PASS_IMM;
        o_rs_use = 1'b0;
        o_rt_use = 1'b0;
        o_we     = 1'b0;
        o_imm    = '0;
        case (opcode)
            OP_ARITH: begin
                o_rs_use = 1'b1;
                o_rt_use = ~i_insn[5];
                o_we     = 1'b1;
                o_imm    = imm5;
                case (i_insn[5:3])
                    3'b000:  o_alu_op = ALU_ADD;
                    3'b001:  o_alu_op = ALU_MUL;
                    3'b010:  o_alu_op = ALU_SUB;
                    // divide is not supported, treated as a nop
                    3'b011: begin
                        o_rs_use = 1'b0;
                        o_rt_use = 1'b0;
                        o_we     = 1'b0;
                    end
                    default: o_alu_op = ALU_ADD;
                endcase
            end
            OP_LOGIC: begin
                o_rs_use = 1'b1;
                o_rt_use = ~i_insn[5];
                o_we     = 1'b1;
                o_imm    = imm5;
                case (i_insn[5:3])
                    3'b000:  o_alu_op = ALU_AND;
                    3'b001: begin
                        o_alu_op = ALU_NOT;
                        o_rt_use = 1'b0;
                    end
                    3'b010:  o_alu_op = ALU_OR;
                    3'b011:  o_alu_op = ALU_XOR;
                    default: o_alu_op = ALU_AND;
                endcase
            end
            OP_CONST: begin
                o_we  = 1'b1;
                o_imm = imm9;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/lc4_alu.sv
// combinational ALU for one execution lane
// immediate forms arrive with i_b already replaced by the immediate
module lc4_alu
    import lc4_pkg::*;
(
    input  alu_op_e         i_op,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    input  logic [XLEN-1:0] i_imm,
    output logic [XLEN-1:0] o_result
);

    always_comb begin
        case (i_op)
            // arithmetic wraps at 16 bits
            ALU_ADD:      o_result = i_a + i_b;
            ALU_MUL:      o_result = i_a * i_b;
            ALU_SUB:      o_result = i_a - i_b;
            ALU_AND:      o_result = i_a & i_b;
            ALU_NOT:      o_result = ~i_a;
            ALU_OR:       o_result = i_a | i_b;
            ALU_XOR:      o_result = i_a ^ i_b;
            ALU_PASS_IMM: o_result = i_imm;
            default:      o_result = i_imm;
        endcase
    end

endmodule

// File: hdl/lc4_issue.sv
// fetch PC, D-stage pair registers and the pair-split decision
// reads an aligned pair each cycle and hands decoded slots to lanes A and B
module lc4_issue
    import lc4_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 16'h8200
) (
    input  logic            gwe,
    input  logic            i_rst_n,
    input  logic [XLEN-1:0] i_insn_a,
    input  logic [XLEN-1:0] i_insn_b,
    output logic [XLEN-1:0] o_pc,
    output logic            o_valid_a,
    output logic [XLEN-1:0] o_pc_a,
    output logic [XLEN-1:0] o_insn_a,
    output alu_op_e         o_alu_op_a,
    output reg_idx_t        o_rd_a,
    output reg_idx_t        o_rs_a,
    output reg_idx_t        o_rt_a,
    output logic            o_rs_use_a,
    output logic            o_rt_use_a,
    output logic            o_we_a,
    output logic [XLEN-1:0] o_imm_a,
    output logic            o_valid_b,
    output logic [XLEN-1:0] o_pc_b,
    output logic [XLEN-1:0] o_insn_b,
    output alu_op_e         o_alu_op_b,
    output reg_idx_t        o_rd_b,
    output reg_idx_t        o_rs_b,
    output reg_idx_t        o_rt_b,
    output logic            o_rs_use_b,
    output logic            o_rt_use_b,
    output logic            o_we_b,
    output logic [XLEN-1:0] o_imm_b
);

    logic [XLEN-1:0] pc_q;
    logic            d_valid_a, d_valid_b;
    logic [XLEN-1:0] d_pc_a, d_pc_b;
    logic [XLEN-1:0] d_insn_a, d_insn_b;
    logic            split;

    lc4_decoder dec_a (
        .i_insn   (d_insn_a),
        .o_alu_op (o_alu_op_a),
        .o_rd     (o_rd_a),
        .o_rs     (o_rs_a),
        .o_rt     (o_rt_a),
        .o_rs_use (o_rs_use_a),
        .o_rt_use (o_rt_use_a),
        .o_we     (o_we_a),
        .o_imm    (o_imm_a)
    );

    lc4_decoder dec_b (
        .i_insn   (d_insn_b),
        .o_alu_op (o_alu_op_b),
        .o_rd     (o_rd_b),
        .o_rs     (o_rs_b),
        .o_rt     (o_rt_b),
        .o_rs_use (o_rs_use_b),
        .o_rt_use (o_rt_use_b),
        .o_we     (o_we_b),
        .o_imm    (o_imm_b)
    );

    // B depends on A inside the pair, so B waits one cycle in slot A
    assign split = d_valid_a && d_valid_b && o_we_a &&
                   ((o_rs_use_b && (o_rs_b == o_rd_a)) ||
                    (o_rt_use_b && (o_rt_b == o_rd_a)));

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q      <= RESET_PC;
            d_valid_a <= 1'b0;
            d_valid_b <= 1'b0;
        end else if (split) begin
            pc_q      <= pc_q + 16'd1;
            d_valid_a <= d_valid_b;
            d_valid_b <= 1'b1;
        end else begin
            pc_q      <= pc_q + 16'd2;
            d_valid_a <= 1'b1;
            d_valid_b <= 1'b1;
        end
    end

    always_ff @(posedge gwe) begin
        if (split) begin
            d_pc_a   <= d_pc_b;
            d_insn_a <= d_insn_b;
            d_pc_b   <= pc_q;
            d_insn_b <= i_insn_a;
        end else begin
            d_pc_a   <= pc_q;
            d_insn_a <= i_insn_a;
            d_pc_b   <= pc_q + 16'd1;
            d_insn_b <= i_insn_b;
        end
    end

    assign o_pc      = pc_q;
    assign o_valid_a = d_valid_a;
    assign o_pc_a    = d_pc_a;
    assign o_insn_a  = d_insn_a;
    // held-back B goes down lane B as a bubble
    assign o_valid_b = d_valid_b && !split;
    assign o_pc_b    = d_pc_b;
    assign o_insn_b  = d_insn_b;

endmodule

// File: hdl/lc4_lane.sv
// one execution pipe: X register, W-to-X bypass, ALU and W register
// both lanes' W results come back in for bypassing, lane B has priority
module lc4_lane
    import lc4_pkg::*;
(
    input  logic            gwe,
    input  logic            i_rst_n,
    input  logic            i_valid,
    input  logic [XLEN-1:0] i_pc,
    input  logic [XLEN-1:0] i_insn,
    input  alu_op_e         i_alu_op,
    input  reg_idx_t        i_rd,
    input  reg_idx_t        i_rs,
    input  reg_idx_t        i_rt,
    input  logic            i_rs_use,
    input  logic            i_rt_use,
    input  logic            i_we,
    input  logic [XLEN-1:0] i_imm,
    input  logic [XLEN-1:0] i_rs_data,
    input  logic [XLEN-1:0] i_rt_data,
    input  logic            i_byp_we_a,
    input  reg_idx_t        i_byp_rd_a,
    input  logic [XLEN-1:0] i_byp_data_a,
    input  logic            i_byp_we_b,
    input  reg_idx_t        i_byp_rd_b,
    input  logic [XLEN-1:0] i_byp_data_b,
    output logic            o_ret_valid,
    output logic [XLEN-1:0] o_ret_pc,
    output logic [XLEN-1:0] o_ret_insn,
    output logic            o_ret_we,
    output reg_idx_t        o_ret_rd,
    output logic [XLEN-1:0] o_ret_data
);

    logic            x_valid, x_we;
    logic [XLEN-1:0] x_pc, x_insn, x_imm;
    alu_op_e         x_alu_op;
    reg_idx_t        x_rd, x_rs, x_rt;
    logic            x_rs_use, x_rt_use;
    logic [XLEN-1:0] x_rs_data, x_rt_data;
    logic [XLEN-1:0] rs_val, rt_val, op_b, result;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            x_valid     <= 1'b0;
            x_we        <= 1'b0;
            o_ret_valid <= 1'b0;
            o_ret_we    <= 1'b0;
        end else begin
            x_valid     <= i_valid;
            // a bubble never writes
            x_we        <= i_valid && i_we;
            o_ret_valid <= x_valid;
            o_ret_we    <= x_we;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc       <= i_pc;
        x_insn     <= i_insn;
        x_alu_op   <= i_alu_op;
        x_rd       <= i_rd;
        x_rs       <= i_rs;
        x_rt       <= i_rt;
        x_rs_use   <= i_rs_use;
        x_rt_use   <= i_rt_use;
        x_imm      <= i_imm;
        x_rs_data  <= i_rs_data;
        x_rt_data  <= i_rt_data;
        o_ret_pc   <= x_pc;
        o_ret_insn <= x_insn;
        o_ret_rd   <= x_rd;
        o_ret_data <= result;
    end

    // lane B in W is younger than lane A in W
    always_comb begin
        if (x_rs_use && i_byp_we_b && (i_byp_rd_b == x_rs)) begin
            rs_val = i_byp_data_b;
        end else if (x_rs_use && i_byp_we_a && (i_byp_rd_a == x_rs)) begin
            rs_val = i_byp_data_a;
        end else begin
            rs_val = x_rs_data;
        end
        if (x_rt_use && i_byp_we_b && (i_byp_rd_b == x_rt)) begin
            rt_val = i_byp_data_b;
        end else if (x_rt_use && i_byp_we_a && (i_byp_rd_a == x_rt)) begin
            rt_val = i_byp_data_a;
        end else begin
            rt_val = x_rt_data;
        end
    end

    assign op_b = x_rt_use ? rt_val : x_imm;

    lc4_alu alu (
        .i_op     (x_alu_op),
        .i_a      (rs_val),
        .i_b      (op_b),
        .i_imm    (x_imm),
        .o_result (result)
    );

endmodule

// File: hdl/lc4_regfile_2w.sv
// eight-entry register file, four read ports and two write ports
// reads see this cycle's W writes, port B wins on a collision
module lc4_regfile_2w
    import lc4_pkg::*;
(
    input  logic            gwe,
    input  logic            i_rst_n,
    input  reg_idx_t        i_rsel_0,
    input  reg_idx_t        i_rsel_1,
    input  reg_idx_t        i_rsel_2,
    input  reg_idx_t        i_rsel_3,
    input  logic            i_we_a,
    input  reg_idx_t        i_rd_a,
    input  logic [XLEN-1:0] i_wdata_a,
    input  logic            i_we_b,
    input  reg_idx_t        i_rd_b,
    input  logic [XLEN-1:0] i_wdata_b,
    output logic [XLEN-1:0] o_rdata_0,
    output logic [XLEN-1:0] o_rdata_1,
    output logic [XLEN-1:0] o_rdata_2,
    output logic [XLEN-1:0] o_rdata_3
);

    logic [XLEN-1:0] regs [NREGS];

    function automatic logic [XLEN-1:0] read_thru(input reg_idx_t sel);
        if (i_we_b && (i_rd_b == sel)) begin
            return i_wdata_b;
        end
        if (i_we_a && (i_rd_a == sel)) begin
            return i_wdata_a;
        end
        return regs[sel];
    endfunction

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_we_a) begin
                regs[i_rd_a] <= i_wdata_a;
            end
            // second assignment overrides A when both hit one register
            if (i_we_b) begin
                regs[i_rd_b] <= i_wdata_b;
            end
        end
    end

    always_comb begin
        o_rdata_0 = read_thru(i_rsel_0);
        o_rdata_1 = read_thru(i_rsel_1);
        o_rdata_2 = read_thru(i_rsel_2);
        o_rdata_3 = read_thru(i_rsel_3);
    end

endmodule

// File: hdl/lc4_ss_core.sv
// top level of the two-way superscalar lc4 core
// fetches o_pc and o_pc+1 every cycle and reports both retiring results
module lc4_ss_core
    import lc4_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 16'h8200
) (
    input  logic            gwe,
    input  logic            i_rst_n,
    input  logic [XLEN-1:0] i_insn_a,
    input  logic [XLEN-1:0] i_insn_b,
    output logic [XLEN-1:0] o_pc,
    output logic            o_ret_valid_a,
    output logic [XLEN-1:0] o_ret_pc_a,
    output logic [XLEN-1:0] o_ret_insn_a,
    output logic            o_ret_we_a,
    output reg_idx_t        o_ret_rd_a,
    output logic [XLEN-1:0] o_ret_data_a,
    output logic            o_ret_valid_b,
    output logic [XLEN-1:0] o_ret_pc_b,
    output logic [XLEN-1:0] o_ret_insn_b,
    output logic            o_ret_we_b,
    output reg_idx_t        o_ret_rd_b,
    output logic [XLEN-1:0] o_ret_data_b
);

    logic            valid_a, valid_b;
    logic [XLEN-1:0] pc_a, pc_b, insn_a, insn_b, imm_a, imm_b;
    alu_op_e         alu_op_a, alu_op_b;
    reg_idx_t        rd_a, rd_b, rs_a, rs_b, rt_a, rt_b;
    logic            rs_use_a, rs_use_b, rt_use_a, rt_use_b, we_a, we_b;
    logic [XLEN-1:0] rs_data_a, rt_data_a, rs_data_b, rt_data_b;

    lc4_issue #(
        .RESET_PC (RESET_PC)
    ) issue (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_insn_a   (i_insn_a),
        .i_insn_b   (i_insn_b),
        .o_pc       (o_pc),
        .o_valid_a  (valid_a),
        .o_pc_a     (pc_a),
        .o_insn_a   (insn_a),
        .o_alu_op_a (alu_op_a),
        .o_rd_a     (rd_a),
        .o_rs_a     (rs_a),
        .o_rt_a     (rt_a),
        .o_rs_use_a (rs_use_a),
        .o_rt_use_a (rt_use_a),
        .o_we_a     (we_a),
        .o_imm_a    (imm_a),
        .o_valid_b  (valid_b),
        .o_pc_b     (pc_b),
        .o_insn_b   (insn_b),
        .o_alu_op_b (alu_op_b),
        .o_rd_b     (rd_b),
        .o_rs_b     (rs_b),
        .o_rt_b     (rt_b),
        .o_rs_use_b (rs_use_b),
        .o_rt_use_b (rt_use_b),
        .o_we_b     (we_b),
        .o_imm_b    (imm_b)
    );

    lc4_regfile_2w regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rsel_0  (rs_a),
        .i_rsel_1  (rt_a),
        .i_rsel_2  (rs_b),
        .i_rsel_3  (rt_b),
        .i_we_a    (o_ret_we_a),
        .i_rd_a    (o_ret_rd_a),
        .i_wdata_a (o_ret_data_a),
        .i_we_b    (o_ret_we_b),
        .i_rd_b    (o_ret_rd_b),
        .i_wdata_b (o_ret_data_b),
        .o_rdata_0 (rs_data_a),
        .o_rdata_1 (rt_data_a),
        .o_rdata_2 (rs_data_b),
        .o_rdata_3 (rt_data_b)
    );

    lc4_lane lane_a (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .i_valid      (valid_a),
        .i_pc         (pc_a),
        .i_insn       (insn_a),
        .i_alu_op     (alu_op_a),
        .i_rd         (rd_a),
        .i_rs         (rs_a),
        .i_rt         (rt_a),
        .i_rs_use     (rs_use_a),
        .i_rt_use     (rt_use_a),
        .i_we         (we_a),
        .i_imm        (imm_a),
        .i_rs_data    (rs_data_a),
        .i_rt_data    (rt_data_a),
        .i_byp_we_a   (o_ret_we_a),
        .i_byp_rd_a   (o_ret_rd_a),
        .i_byp_data_a (o_ret_data_a),
        .i_byp_we_b   (o_ret_we_b),
        .i_byp_rd_b   (o_ret_rd_b),
        .i_byp_data_b (o_ret_data_b),
        .o_ret_valid  (o_ret_valid_a),
        .o_ret_pc     (o_ret_pc_a),
        .o_ret_insn   (o_ret_insn_a),
        .o_ret_we     (o_ret_we_a),
        .o_ret_rd     (o_ret_rd_a),
        .o_ret_data   (o_ret_data_a)
    );

    lc4_lane lane_b (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .i_valid      (valid_b),
        .i_pc         (pc_b),
        .i_insn       (insn_b),
        .i_alu_op     (alu_op_b),
        .i_rd         (rd_b),
        .i_rs         (rs_b),
        .i_rt         (rt_b),
        .i_rs_use     (rs_use_b),
        .i_rt_use     (rt_use_b),
        .i_we         (we_b),
        .i_imm        (imm_b),
        .i_rs_data    (rs_data_b),
        .i_rt_data    (rt_data_b),
        .i_byp_we_a   (o_ret_we_a),
        .i_byp_rd_a   (o_ret_rd_a),
        .i_byp_data_a (o_ret_data_a),
        .i_byp_we_b   (o_ret_we_b),
        .i_byp_rd_b   (o_ret_rd_b),
        .i_byp_data_b (o_ret_data_b),
        .o_ret_valid  (o_ret_valid_b),
        .o_ret_pc     (o_ret_pc_b),
        .o_ret_insn   (o_ret_insn_b),
        .o_ret_we     (o_ret_we_b),
        .o_ret_rd     (o_ret_rd_b),
        .o_ret_data   (o_ret_data_b)
    );

endmodule

// File: sim/tb_lc4_ss.sv
// testbench for the two-way lc4 core: random program with directed segments,
// in-order reference model with pair grouping, retire and fetch PC checks
module tb_lc4_ss
    import lc4_pkg::*;
;

    localparam logic [XLEN-1:0] RESET_PC = 16'h8200;
    localparam int N_INSN   = 200;
    localparam int MEM_LEN  = 256;
    localparam int WATCHDOG = (2 * N_INSN + 40) * 8;
    localparam int CHAIN_AT = 60;
    localparam int SEG1_AT  = 120;
    localparam int SEG2_AT  = 150;
    localparam int N_DIR    = 3;

    // instruction kinds known to the generator and the model
    localparam int K_NOP   = 0,
                   K_ADD   = 1,
                   K_MUL   = 2,
                   K_SUB   = 3,
                   K_ADDI  = 4,
                   K_AND   = 5,
                   K_NOT   = 6,
                   K_OR    = 7,
                   K_XOR   = 8,
                   K_ANDI  = 9,
                   K_CONST = 10;

    logic            gwe;
    logic            i_rst_n;
    logic [XLEN-1:0] i_insn_a;
    logic [XLEN-1:0] i_insn_b;
    logic [XLEN-1:0] o_pc;
    logic            o_ret_valid_a;
    logic [XLEN-1:0] o_ret_pc_a;
    logic [XLEN-1:0] o_ret_insn_a;
    logic            o_ret_we_a;
    reg_idx_t        o_ret_rd_a;
    logic [XLEN-1:0] o_ret_data_a;
    logic            o_ret_valid_b;
    logic [XLEN-1:0] o_ret_pc_b;
    logic [XLEN-1:0] o_ret_insn_b;
    logic            o_ret_we_b;
    reg_idx_t        o_ret_rd_b;
    logic [XLEN-1:0] o_ret_data_b;

    // program image and what the generator knows about each word
    logic [XLEN-1:0] mem [MEM_LEN];
    int              m_kind [MEM_LEN];
    logic [2:0]      m_rd [MEM_LEN];
    logic [2:0]      m_rs [MEM_LEN];
    logic [2:0]      m_rt [MEM_LEN];
    logic            m_rs_use [MEM_LEN];
    logic            m_rt_use [MEM_LEN];
    logic            m_we [MEM_LEN];
    logic [XLEN-1:0] m_imm [MEM_LEN];
    logic [XLEN-1:0] exp_data [MEM_LEN];
    int              gstart [MEM_LEN];
    int              gsize [MEM_LEN];
    int              dir_idx [N_DIR];
    logic [XLEN-1:0] dir_val [N_DIR];
    int              n_cycles;
    integer          seed = 32'h38e7;

    lc4_ss_core #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .gwe           (gwe),
        .i_rst_n       (i_rst_n),
        .i_insn_a      (i_insn_a),
        .i_insn_b      (i_insn_b),
        .o_pc          (o_pc),
        .o_ret_valid_a (o_ret_valid_a),
        .o_ret_pc_a    (o_ret_pc_a),
        .o_ret_insn_a  (o_ret_insn_a),
        .o_ret_we_a    (o_ret_we_a),
        .o_ret_rd_a    (o_ret_rd_a),
        .o_ret_data_a  (o_ret_data_a),
        .o_ret_valid_b (o_ret_valid_b),
        .o_ret_pc_b    (o_ret_pc_b),
        .o_ret_insn_b  (o_ret_insn_b),
        .o_ret_we_b    (o_ret_we_b),
        .o_ret_rd_b    (o_ret_rd_b),
        .o_ret_data_b  (o_ret_data_b)
    );

    initial begin
        gwe = 1'b0;
        forever #4 gwe = ~gwe;
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: the core did not retire the program within %0d time units", WATCHDOG);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic set_insn(input int idx, input int kind, input logic [2:0] rd,
                            input logic [2:0] rs, input logic [2:0] rt, input logic [8:0] imm);
        logic [XLEN-1:0] w;
        case (kind)
            K_ADD:   w = {4'b0001, rd, rs, 3'b000, rt};
            K_MUL:   w = {4'b0001, rd, rs, 3'b001, rt};
            K_SUB:   w = {4'b0001, rd, rs, 3'b010, rt};
            K_ADDI:  w = {4'b0001, rd, rs, 1'b1, imm[4:0]};
            K_AND:   w = {4'b0101, rd, rs, 3'b000, rt};
            K_NOT:   w = {4'b0101, rd, rs, 3'b001, 3'b000};
            K_OR:    w = {4'b0101, rd, rs, 3'b010, rt};
            K_XOR:   w = {4'b0101, rd, rs, 3'b011, rt};
            K_ANDI:  w = {4'b0101, rd, rs, 1'b1, imm[4:0]};
            K_CONST: w = {4'b1001, rd, imm};
            default: w = {4'b0000, rd, imm};
        endcase
        mem[idx]      = w;
        m_kind[idx]   = kind;
        m_rd[idx]     = rd;
        m_rs[idx]     = rs;
        m_rt[idx]     = rt;
        m_we[idx]     = (kind != K_NOP);
        m_rs_use[idx] = (kind != K_NOP) && (kind != K_CONST);
        m_rt_use[idx] = (kind == K_ADD) || (kind == K_MUL) || (kind == K_SUB) ||
                        (kind == K_AND) || (kind == K_OR) || (kind == K_XOR);
        if (kind == K_CONST) begin
            m_imm[idx] = {{7{imm[8]}}, imm};
        end else begin
            m_imm[idx] = {{11{imm[4]}}, imm[4:0]};
        end
    endtask

    // three picks in four land in r0..r3 so dependences stay frequent
    task automatic pick_reg(output logic [2:0] r);
        logic [31:0] v;
        v = $random(seed);
        if (v[3:2] != 2'b00) begin
            r = {1'b0, v[1:0]};
        end else begin
            r = v[6:4];
        end
    endtask

    task automatic gen_random_insn(input int idx);
        logic [31:0] v;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        int          kind;
        v = $random(seed);
        pick_reg(rd);
        pick_reg(rs);
        pick_reg(rt);
        kind = v[7:0] % 11;
        set_insn(idx, kind, rd, rs, rt, v[16:8]);
    endtask

    // the dependent r4 pair always leaves its ADD in slot A, so the two r2
    // writers that follow always issue together as one pair
    task automatic add_r2_segment(input int at, input int gap, input int d);
        logic [31:0] v;
        logic [8:0]  x;
        v = $random(seed);
        x = v[8:0];
        set_insn(at, K_CONST, 3'd4, 3'd0, 3'd0, v[24:16]);
        set_insn(at + 1, K_ADDI, 3'd4, 3'd4, 3'd0, 9'd1);
        set_insn(at + 2, K_NOP, 3'd0, 3'd0, 3'd0, 9'd0);
        set_insn(at + 3, K_CONST, 3'd2, 3'd0, 3'd0, x);
        set_insn(at + 4, K_CONST, 3'd2, 3'd0, 3'd0, ~x);
        for (int i = 0; i < gap; i++) begin
            set_insn(at + 5 + i, K_NOP, 3'd0, 3'd0, 3'd0, 9'd0);
        end
        set_insn(at + 5 + gap, K_ADDI, 3'd3, 3'd2, 3'd0, 9'd0);
        // reader must see the younger lane B value
        dir_idx[d] = at + 5 + gap;
        dir_val[d] = {{7{~x[8]}}, ~x};
    endtask

    task automatic build_program();
        for (int i = 0; i < MEM_LEN; i++) begin
            if (i < N_INSN) begin
                gen_random_insn(i);
            end else begin
                set_insn(i, K_NOP, 3'd0, 3'd0, 3'd0, 9'd0);
            end
        end
        for (int i = 0; i < 20; i++) begin
            set_insn(CHAIN_AT + i, K_ADDI, 3'd1, 3'd1, 3'd0, 9'd1);
        end
        // gap 0 goes through the bypass, gap 2 through regfile write-through
        add_r2_segment(SEG1_AT, 0, 1);
        add_r2_segment(SEG2_AT, 2, 2);
    endtask

    task automatic run_model();
        logic [XLEN-1:0] mreg [8];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        int              i;
        int              g;
        for (int k = 0; k < 8; k++) begin
            mreg[k] = '0;
        end
        for (int k = 0; k < MEM_LEN; k++) begin
            if (k == CHAIN_AT) begin
                dir_idx[0] = CHAIN_AT + 19;
                dir_val[0] = mreg[1] + 16'd20;
            end
            a = mreg[m_rs[k]];
            b = m_rt_use[k] ? mreg[m_rt[k]] : m_imm[k];
            case (m_kind[k])
                K_ADD, K_ADDI: r = a + b;
                K_MUL:         r = a * b;
                K_SUB:         r = a - b;
                K_AND, K_ANDI: r = a & b;
                K_NOT:         r = ~a;
                K_OR:          r = a | b;
                K_XOR:         r = a ^ b;
                default:       r = m_imm[k];
            endcase
            exp_data[k] = r;
            if (m_we[k]) begin
                mreg[m_rd[k]] = r;
            end
        end
        // issue groups: the second word waits when it reads what the first writes
        i = 0;
        g = 0;
        n_cycles = 0;
        while (i < MEM_LEN - 1) begin
            gstart[g] = i;
            if (m_we[i] && ((m_rs_use[i + 1] && (m_rs[i + 1] == m_rd[i])) ||
                            (m_rt_use[i + 1] && (m_rt[i + 1] == m_rd[i])))) begin
                gsize[g] = 1;
            end else begin
                gsize[g] = 2;
            end
            if ((n_cycles == 0) && (i >= N_INSN)) begin
                n_cycles = g + 4;
            end
            i = i + gsize[g];
            g = g + 1;
        end
    endtask

    function automatic logic [XLEN-1:0] fetch(input logic [XLEN-1:0] addr);
        int idx;
        idx = int'(addr - RESET_PC);
        if (idx < MEM_LEN) begin
            return mem[idx];
        end
        return 16'h0000;
    endfunction

    task automatic drive_fetch();
        i_insn_a = fetch(o_pc);
        i_insn_b = fetch(o_pc + 16'd1);
    endtask

    task automatic check_slot(input string lane, input int idx, input logic valid,
                              input logic [XLEN-1:0] pc, input logic [XLEN-1:0] insn,
                              input logic we, input logic [2:0] rd,
                              input logic [XLEN-1:0] data);
        string tag;
        tag = $sformatf("lane %s insn %0d", lane, idx);
        expect_equal(valid, 1, {tag, " retire valid"});
        expect_equal(pc, RESET_PC + idx, {tag, " pc"});
        expect_equal(insn, mem[idx], {tag, " insn"});
        expect_equal(we, m_we[idx], {tag, " we"});
        if (m_we[idx]) begin
            expect_equal(rd, m_rd[idx], {tag, " rd"});
            expect_equal(data, exp_data[idx], {tag, " data"});
        end
        for (int d = 0; d < N_DIR; d++) begin
            if (dir_idx[d] == idx) begin
                expect_equal(data, dir_val[d], {tag, " directed result"});
            end
        end
    endtask

    initial begin
        int j;
        i_rst_n  = 1'b0;
        i_insn_a = '0;
        i_insn_b = '0;
        build_program();
        run_model();
        repeat (10) begin
            @(negedge gwe);
            expect_equal(o_pc, RESET_PC, "o_pc during reset");
            expect_equal(o_ret_valid_a, 0, "retire A valid during reset");
            expect_equal(o_ret_valid_b, 0, "retire B valid during reset");
            drive_fetch();
        end
        i_rst_n = 1'b1;
        for (int c = 1; c <= n_cycles; c++) begin
            @(negedge gwe);
            expect_equal(o_pc, RESET_PC + gstart[c - 1] + 2,
                         $sformatf("o_pc after fetch edge %0d", c));
            if (c < 3) begin
                expect_equal(o_ret_valid_a, 0, "retire A valid before first retire");
                expect_equal(o_ret_valid_b, 0, "retire B valid before first retire");
            end else begin
                j = c - 3;
                check_slot("A", gstart[j], o_ret_valid_a, o_ret_pc_a, o_ret_insn_a,
                           o_ret_we_a, o_ret_rd_a, o_ret_data_a);
                if (gsize[j] == 2) begin
                    check_slot("B", gstart[j] + 1, o_ret_valid_b, o_ret_pc_b, o_ret_insn_b,
                               o_ret_we_b, o_ret_rd_b, o_ret_data_b);
                end else begin
                    expect_equal(o_ret_valid_b, 0, $sformatf("split group %0d B valid", j));
                    expect_equal(o_ret_we_b, 0, $sformatf("split group %0d B we", j));
                end
            end
            drive_fetch();
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: tb.f
hdl/lc4_pkg.sv
hdl/lc4_decoder.sv
hdl/lc4_alu.sv
hdl/lc4_issue.sv
hdl/lc4_lane.sv
hdl/lc4_regfile_2w.sv
hdl/lc4_ss_core.sv
sim/tb_lc4_ss.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_lc4_ss -f tb.f -o tb_lc4_ss &&
./obj_dir/tb_lc4_ss | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
